/* src/ooo_pkg.sv */
package ooo_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int XLEN      = 32;
    localparam int NUM_REGS  = 8;
    // rob entries, also sets the tag width
    localparam int ROB_DEPTH = 8;

    typedef logic [XLEN-1:0]                data_t;
    typedef logic [$clog2(NUM_REGS)-1:0]    reg_idx_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0]   rob_tag_t;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_MUL
    } op_e;

    // lane arithmetic unit
    typedef enum logic [1:0] {
        LD_IDLE,
        LD_MUL,
        LD_HOLD
    } ld_state_e;

    ////////////////////////////////////////
    // bundles
    ////////////////////////////////////////

    // instruction word at the core input
    typedef struct packed {
        op_e      op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } inst_t;

    // renamed source, either a value or a pending tag
    typedef struct packed {
        logic     ready;
        rob_tag_t tag;
        data_t    value;
    } operand_t;

    typedef struct packed {
        op_e      op;
        rob_tag_t dest;
        operand_t src1;
        operand_t src2;
    } rs_entry_t;

    // common data bus
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        data_t    value;
    } cdb_t;

    typedef struct packed {
        reg_idx_t rd;
        rob_tag_t tag;
        data_t    value;
    } commit_t;

    typedef struct packed {
        logic     busy;
        logic     done;
        reg_idx_t rd;
        data_t    value;
    } rob_entry_t;

endpackage

/* src/dispatch_unit.sv */
`timescale 1ns/1ps

module dispatch_unit #(
    parameter int NUM_LANES = 3
) (
    input  logic                                             clock,
    input  logic                                             reset,
    input  logic                                             inst_valid,
    input  ooo_pkg::inst_t                                   inst,
    input  logic                                             rob_full,
    input  ooo_pkg::rob_tag_t                                alloc_tag,
    input  ooo_pkg::rob_entry_t [ooo_pkg::ROB_DEPTH-1:0]     rob_entries,
    input  logic [NUM_LANES-1:0]                             lane_free,
    input  logic [ooo_pkg::NUM_REGS-1:0]                     map_busy,
    input  ooo_pkg::rob_tag_t [ooo_pkg::NUM_REGS-1:0]        map_tag,
    input  ooo_pkg::data_t [ooo_pkg::NUM_REGS-1:0]           reg_values,
    input  ooo_pkg::cdb_t                                    cdb,
    output logic                                             inst_ready,
    output logic                                             alloc_valid,
    output ooo_pkg::reg_idx_t                                alloc_rd,
    output logic                                             rename_valid,
    output ooo_pkg::reg_idx_t                                rename_rd,
    output ooo_pkg::rob_tag_t                                rename_tag,
    output logic [NUM_LANES-1:0]                             lane_load,
    output ooo_pkg::rs_entry_t                               lane_entry
);
    import ooo_pkg::*;

    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic             fire;
    logic [PTR_W-1:0] rot_ptr;
    logic [PTR_W-1:0] pick_idx;
    operand_t         src1_op;
    operand_t         src2_op;

    // rename one source
    // regfile, then finished rob entry, then the bus this cycle, else wait
    function automatic operand_t resolve(input reg_idx_t r);
        operand_t o;
        o.tag   = map_tag[r];
        o.ready = 1'b1;
        o.value = reg_values[r];
        if (map_busy[r]) begin
            if (rob_entries[map_tag[r]].done) begin
                o.value = rob_entries[map_tag[r]].value;
            end else if (cdb.valid && cdb.tag == map_tag[r]) begin
                o.value = cdb.value;
            end else begin
                o.ready = 1'b0;
                o.value = '0;
            end
        end
        return o;
    endfunction

    ////////////////////////////////////////
    // handshake
    ////////////////////////////////////////

    assign inst_ready = !reset && !rob_full && (|lane_free);
    assign fire       = inst_valid && inst_ready;

    // rob allocation and rename share the transfer
    assign alloc_valid  = fire;
    assign alloc_rd     = inst.rd;
    assign rename_valid = fire;
    assign rename_rd    = inst.rd;
    assign rename_tag   = alloc_tag;

    ////////////////////////////////////////
    // lane steering
    ////////////////////////////////////////

    // first free lane at or after the rotation pointer
    always_comb begin
        pick_idx = rot_ptr;
        for (int k = NUM_LANES - 1; k >= 0; k--) begin
            if (lane_free[(int'(rot_ptr) + k) % NUM_LANES]) begin
                pick_idx = PTR_W'((int'(rot_ptr) + k) % NUM_LANES);
            end
        end
    end

    assign lane_load = fire ? (NUM_LANES'(1) << pick_idx) : '0;

    always_comb begin
        src1_op = resolve(inst.rs1);
        src2_op = resolve(inst.rs2);
    end

    assign lane_entry = '{op: inst.op, dest: alloc_tag, src1: src1_op, src2: src2_op};

    // move past the lane just loaded
    always_ff @(posedge clock) begin
        if (reset) begin
            rot_ptr <= '0;
        end else if (fire) begin
            rot_ptr <= (int'(pick_idx) == NUM_LANES - 1) ? '0 : pick_idx + 1'b1;
        end
    end

endmodule

/* src/exec_lane.sv */
`timescale 1ns/1ps

module exec_lane #(
    parameter int RS_DEPTH   = 2,
    parameter int MUL_CYCLES = 3
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               load,
    input  ooo_pkg::rs_entry_t entry,
    input  ooo_pkg::cdb_t      cdb,
    input  logic               grant,
    output logic               free,
    output logic               done_valid,
    output ooo_pkg::cdb_t      done_result
);
    import ooo_pkg::*;

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
    localparam int CNT_W = $clog2(MUL_CYCLES + 1);

    // station slots
    rs_entry_t           st [RS_DEPTH];
    logic [RS_DEPTH-1:0] st_valid;
    // older[i][j] set when slot j was loaded before slot i
    logic [RS_DEPTH-1:0] older [RS_DEPTH];
    logic [RS_DEPTH-1:0] rdy;
    logic [IDX_W-1:0]    ld_idx;
    logic [IDX_W-1:0]    iss_idx;
    logic                iss_any;
    logic                issue;

    // arithmetic unit
    ld_state_e           state;
    logic [CNT_W-1:0]    mul_cnt;
    data_t               mul_a;
    data_t               mul_b;
    rob_tag_t            res_tag;
    data_t               res_value;

    function automatic data_t alu(input op_e op, input data_t a, input data_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            // low half of the product
            OP_MUL:  return a * b;
            default: return '0;
        endcase
    endfunction

    ////////////////////////////////////////
    // reservation station
    ////////////////////////////////////////

    assign free = ~&st_valid;

    // lowest empty slot
    always_comb begin
        ld_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!st_valid[i]) begin
                ld_idx = IDX_W'(i);
            end
        end
    end

    // oldest slot with both operands in hand
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            rdy[i] = st_valid[i] && st[i].src1.ready && st[i].src2.ready;
        end
        iss_any = 1'b0;
        iss_idx = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (rdy[i] && ((older[i] & rdy) == '0)) begin
                iss_any = 1'b1;
                iss_idx = IDX_W'(i);
            end
        end
    end

    assign issue = iss_any && (state == LD_IDLE);

    always_ff @(posedge clock) begin
        if (reset) begin
            st_valid <= '0;
        end else begin
            // wakeup from the bus
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (st_valid[i] && cdb.valid) begin
                    if (!st[i].src1.ready && st[i].src1.tag == cdb.tag) begin
                        st[i].src1.ready <= 1'b1;
                        st[i].src1.value <= cdb.value;
                    end
                    if (!st[i].src2.ready && st[i].src2.tag == cdb.tag) begin
                        st[i].src2.ready <= 1'b1;
                        st[i].src2.value <= cdb.value;
                    end
                end
            end
            if (issue) begin
                st_valid[iss_idx] <= 1'b0;
            end
            if (load) begin
                st[ld_idx]       <= entry;
                st_valid[ld_idx] <= 1'b1;
                // new slot is younger than everyone
                for (int i = 0; i < RS_DEPTH; i++) begin
                    older[i][ld_idx] <= 1'b0;
                end
                older[ld_idx] <= st_valid;
            end
        end
    end

    ////////////////////////////////////////
    // arithmetic unit
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= LD_IDLE;
        end else begin
            case (state)
                LD_IDLE: begin
                    if (issue) begin
                        res_tag <= st[iss_idx].dest;
                        if (st[iss_idx].op == OP_MUL && MUL_CYCLES > 1) begin
                            mul_a   <= st[iss_idx].src1.value;
                            mul_b   <= st[iss_idx].src2.value;
                            mul_cnt <= CNT_W'(MUL_CYCLES - 2);
                            state   <= LD_MUL;
                        end else begin
                            res_value <= alu(st[iss_idx].op, st[iss_idx].src1.value,
                                             st[iss_idx].src2.value);
                            state     <= LD_HOLD;
                        end
                    end
                end
                // count down the multiply latency
                LD_MUL: begin
                    if (mul_cnt == '0) begin
                        res_value <= alu(OP_MUL, mul_a, mul_b);
                        state     <= LD_HOLD;
                    end else begin
                        mul_cnt <= mul_cnt - 1'b1;
                    end
                end
                // result parked until the arbiter takes it
                LD_HOLD: begin
                    if (grant) begin
                        state <= LD_IDLE;
                    end
                end
                default: state <= LD_IDLE;
            endcase
        end
    end

    assign done_valid  = (state == LD_HOLD);
    assign done_result = '{valid: done_valid, tag: res_tag, value: res_value};

endmodule

/* src/cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter #(
    parameter int NUM_LANES = 3
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic [NUM_LANES-1:0]           done_valid,
    input  ooo_pkg::cdb_t [NUM_LANES-1:0]  done_result,
    output logic [NUM_LANES-1:0]           grant,
    output ooo_pkg::cdb_t                  cdb
);

    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [PTR_W-1:0] rr_ptr;
    logic [PTR_W-1:0] win_idx;
    logic             win_any;

    // first requester at or after the pointer
    always_comb begin
        win_any = 1'b0;
        win_idx = rr_ptr;
        for (int k = NUM_LANES - 1; k >= 0; k--) begin
            if (done_valid[(int'(rr_ptr) + k) % NUM_LANES]) begin
                win_any = 1'b1;
                win_idx = PTR_W'((int'(rr_ptr) + k) % NUM_LANES);
            end
        end
    end

    assign grant = win_any ? (NUM_LANES'(1) << win_idx) : '0;

    // broadcast straight from the winning lane
    always_comb begin
        cdb       = done_result[win_idx];
        cdb.valid = win_any;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rr_ptr <= '0;
        end else if (win_any) begin
            rr_ptr <= (int'(win_idx) == NUM_LANES - 1) ? '0 : win_idx + 1'b1;
        end
    end

endmodule

/* src/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                                         clock,
    input  logic                                         reset,
    input  logic                                         alloc_valid,
    input  ooo_pkg::reg_idx_t                            alloc_rd,
    input  ooo_pkg::cdb_t                                cdb,
    output ooo_pkg::rob_tag_t                            alloc_tag,
    output logic                                         rob_full,
    output ooo_pkg::rob_entry_t [ooo_pkg::ROB_DEPTH-1:0] rob_entries,
    output logic                                         commit_valid,
    output ooo_pkg::commit_t                             commit
);
    import ooo_pkg::*;

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    rob_tag_t         head;
    rob_tag_t         tail;
    logic [CNT_W-1:0] count;

    // new tag is the tail slot
    assign alloc_tag = tail;
    assign rob_full  = (count == CNT_W'(ROB_DEPTH));

    ////////////////////////////////////////
    // retirement
    ////////////////////////////////////////

    // head retires the cycle after its result lands
    assign commit_valid = rob_entries[head].busy && rob_entries[head].done;
    assign commit       = '{rd: rob_entries[head].rd, tag: head, value: rob_entries[head].value};

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                rob_entries[i].busy <= 1'b0;
                rob_entries[i].done <= 1'b0;
            end
        end else begin
            // result capture
            if (cdb.valid) begin
                rob_entries[cdb.tag].done  <= 1'b1;
                rob_entries[cdb.tag].value <= cdb.value;
            end
            if (commit_valid) begin
                rob_entries[head].busy <= 1'b0;
                head                   <= head + 1'b1;
            end
            // allocation at the tail
            if (alloc_valid) begin
                rob_entries[tail] <= '{busy: 1'b1, done: 1'b0, rd: alloc_rd, value: '0};
                tail              <= tail + 1'b1;
            end
            // occupancy
            case ({alloc_valid, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* src/register_status.sv */
`timescale 1ns/1ps

module register_status (
    input  logic                                      clock,
    input  logic                                      reset,
    input  logic                                      rename_valid,
    input  ooo_pkg::reg_idx_t                         rename_rd,
    input  ooo_pkg::rob_tag_t                         rename_tag,
    input  logic                                      commit_valid,
    input  ooo_pkg::commit_t                          commit,
    output logic [ooo_pkg::NUM_REGS-1:0]              map_busy,
    output ooo_pkg::rob_tag_t [ooo_pkg::NUM_REGS-1:0] map_tag,
    output ooo_pkg::data_t [ooo_pkg::NUM_REGS-1:0]    reg_values
);

    ////////////////////////////////////////
    // regfile and rename map
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            reg_values <= '0;
            map_busy   <= '0;
        end else begin
            if (commit_valid) begin
                reg_values[commit.rd] <= commit.value;
                // only drop the map if no younger producer took over
                if (map_busy[commit.rd] && map_tag[commit.rd] == commit.tag) begin
                    map_busy[commit.rd] <= 1'b0;
                end
            end
            // same-cycle rename wins over the clear
            if (rename_valid) begin
                map_busy[rename_rd] <= 1'b1;
                map_tag[rename_rd]  <= rename_tag;
            end
        end
    end

endmodule

/* src/ooo_core.sv */
`timescale 1ns/1ps

module ooo_core #(
    parameter int NUM_LANES  = 3,
    parameter int RS_DEPTH   = 2,
    parameter int MUL_CYCLES = 3
) (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   inst_valid,
    input  ooo_pkg::inst_t                         inst,
    output logic                                   inst_ready,
    output logic                                   commit_valid,
    output ooo_pkg::commit_t                       commit,
    output ooo_pkg::data_t [ooo_pkg::NUM_REGS-1:0] regs
);
    import ooo_pkg::*;

    // dispatch to rob and rename
    logic                             alloc_valid;
    reg_idx_t                         alloc_rd;
    rob_tag_t                         alloc_tag;
    logic                             rob_full;
    rob_entry_t [ROB_DEPTH-1:0]       rob_entries;
    logic                             rename_valid;
    reg_idx_t                         rename_rd;
    rob_tag_t                         rename_tag;
    logic [NUM_REGS-1:0]              map_busy;
    rob_tag_t [NUM_REGS-1:0]          map_tag;
    data_t [NUM_REGS-1:0]             reg_values;

    // lanes and bus
    logic [NUM_LANES-1:0]             lane_free;
    logic [NUM_LANES-1:0]             lane_load;
    rs_entry_t                        lane_entry;
    logic [NUM_LANES-1:0]             done_valid;
    cdb_t [NUM_LANES-1:0]             done_result;
    logic [NUM_LANES-1:0]             grant;
    cdb_t                             cdb;

    ////////////////////////////////////////
    // dispatch
    ////////////////////////////////////////

    dispatch_unit #(
        .NUM_LANES(NUM_LANES)
    ) dispatch_i (
        .clock        (clock),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .rob_full     (rob_full),
        .alloc_tag    (alloc_tag),
        .rob_entries  (rob_entries),
        .lane_free    (lane_free),
        .map_busy     (map_busy),
        .map_tag      (map_tag),
        .reg_values   (reg_values),
        .cdb          (cdb),
        .inst_ready   (inst_ready),
        .alloc_valid  (alloc_valid),
        .alloc_rd     (alloc_rd),
        .rename_valid (rename_valid),
        .rename_rd    (rename_rd),
        .rename_tag   (rename_tag),
        .lane_load    (lane_load),
        .lane_entry   (lane_entry)
    );

    ////////////////////////////////////////
    // execution lanes
    ////////////////////////////////////////

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        exec_lane #(
            .RS_DEPTH   (RS_DEPTH),
            .MUL_CYCLES (MUL_CYCLES)
        ) lane_i (
            .clock       (clock),
            .reset       (reset),
            .load        (lane_load[g]),
            .entry       (lane_entry),
            .cdb         (cdb),
            .grant       (grant[g]),
            .free        (lane_free[g]),
            .done_valid  (done_valid[g]),
            .done_result (done_result[g])
        );
    end

    // one result per cycle onto the bus
    cdb_arbiter #(
        .NUM_LANES(NUM_LANES)
    ) arbiter_i (
        .clock       (clock),
        .reset       (reset),
        .done_valid  (done_valid),
        .done_result (done_result),
        .grant       (grant),
        .cdb         (cdb)
    );

    ////////////////////////////////////////
    // completion and retirement
    ////////////////////////////////////////

    reorder_buffer rob_i (
        .clock        (clock),
        .reset        (reset),
        .alloc_valid  (alloc_valid),
        .alloc_rd     (alloc_rd),
        .cdb          (cdb),
        .alloc_tag    (alloc_tag),
        .rob_full     (rob_full),
        .rob_entries  (rob_entries),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    register_status regstat_i (
        .clock        (clock),
        .reset        (reset),
        .rename_valid (rename_valid),
        .rename_rd    (rename_rd),
        .rename_tag   (rename_tag),
        .commit_valid (commit_valid),
        .commit       (commit),
        .map_busy     (map_busy),
        .map_tag      (map_tag),
        .reg_values   (reg_values)
    );

    assign regs = reg_values;

endmodule

/* sim/ooo_core_tb.sv */
`timescale 1ns/1ps

module ooo_core_tb;
    import ooo_pkg::*;

    localparam int NUM_LANES  = 3;
    localparam int RS_DEPTH   = 2;
    localparam int MUL_CYCLES = 3;
    localparam int CLK_NS     = 8;

    // stream sections
    localparam int N_RANDOM   = 220;
    localparam int N_CHAIN    = 80;
    localparam int N_MULBURST = 24;
    localparam int N_FAST     = 24;
    localparam int N_STREAM   = 52;
    localparam int NUM_INST   = N_RANDOM + N_CHAIN + N_MULBURST + N_FAST + N_STREAM;
    // generous slack on top of the worst serial latency
    localparam int WATCHDOG_NS = (NUM_INST * MUL_CYCLES + 20) * CLK_NS + NUM_INST * 8 * CLK_NS;

    logic                   clock;
    logic                   reset;
    logic                   inst_valid;
    inst_t                  inst;
    logic                   inst_ready;
    logic                   commit_valid;
    commit_t                commit;
    data_t [NUM_REGS-1:0]   regs;

    logic [31:0] lfsr_state;
    inst_t       stim_q [$];
    int          gap_q [$];
    commit_t     expected_q [$];
    data_t       model_regs [NUM_REGS];
    rob_tag_t    next_tag;
    int          accepted_count;
    int          commit_count;
    int          stall_count;
    int          check_count;
    int          error_count;

    ooo_core #(
        .NUM_LANES  (NUM_LANES),
        .RS_DEPTH   (RS_DEPTH),
        .MUL_CYCLES (MUL_CYCLES)
    ) ooo_core_i (
        .clock        (clock),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_ready   (inst_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .regs         (regs)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_NS / 2) clock = ~clock;
    end

    ////////////////////////////////////////
    // random source
    ////////////////////////////////////////

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // in-order execution, one expected commit per instruction
    function automatic void ref_execute(input inst_t word);
        data_t   a;
        data_t   b;
        data_t   r;
        commit_t c;
        a = model_regs[word.rs1];
        b = model_regs[word.rs2];
        case (word.op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLL:  r = a << b[4:0];
            OP_MUL:  r = a * b;
            default: r = '0;
        endcase
        model_regs[word.rd] = r;
        c.rd    = word.rd;
        c.tag   = next_tag;
        c.value = r;
        expected_q.push_back(c);
        // tags run 0, 1, 2 ... and wrap at the rob depth
        next_tag = next_tag + 1'b1;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] want);
        check_count++;
        if (got !== want) begin
            $display("Fail %0t ns: %s is %h, expected %h", $time, what, got, want);
            error_count++;
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic build_stimulus();
        inst_t    word;
        reg_idx_t prev_rd;
        // random mix with idle gaps between offers
        for (int i = 0; i < N_RANDOM; i++) begin
            word.op  = op_e'(3'(random_bits(3) % 7));
            word.rd  = reg_idx_t'(random_bits(3));
            word.rs1 = reg_idx_t'(random_bits(3));
            word.rs2 = reg_idx_t'(random_bits(3));
            stim_q.push_back(word);
            gap_q.push_back((random_bits(1) == 32'd1) ? int'(random_bits(2)) : 0);
        end
        // chain picks up from the last random destination
        prev_rd = word.rd;
        // each reads the previous rd with multiplies feeding other ops
        for (int i = 0; i < N_CHAIN; i++) begin
            word.op  = (i % 2 == 0) ? OP_MUL : op_e'(3'(random_bits(3) % 6));
            word.rd  = reg_idx_t'(random_bits(3));
            word.rs1 = prev_rd;
            word.rs2 = reg_idx_t'(random_bits(3));
            prev_rd  = word.rd;
            stim_q.push_back(word);
            gap_q.push_back(0);
        end
        // independent multiplies write r4 to r7 from r0 to r3
        // fast ops stay in r0 to r3 and finish first
        for (int i = 0; i < N_MULBURST + N_FAST; i++) begin
            word.op  = (i < N_MULBURST) ? OP_MUL : op_e'(3'(random_bits(3) % 6));
            word.rd  = reg_idx_t'((i < N_MULBURST) ? 4 + i % 4 : i % 4);
            word.rs1 = reg_idx_t'(random_bits(2));
            word.rs2 = reg_idx_t'(random_bits(2));
            stim_q.push_back(word);
            gap_q.push_back(0);
        end
        // back to back so the rob fills up
        for (int i = 0; i < N_STREAM; i++) begin
            word.op  = op_e'(3'(random_bits(3) % 7));
            word.rd  = reg_idx_t'(random_bits(3));
            word.rs1 = reg_idx_t'(random_bits(3));
            word.rs2 = reg_idx_t'(random_bits(3));
            stim_q.push_back(word);
            gap_q.push_back(0);
        end
    endtask

    // offer on the falling edge, hold until taken
    task automatic send_all();
        inst_t cur;
        int    gap;
        logic  taken;
        while (stim_q.size() > 0) begin
            cur = stim_q.pop_front();
            gap = gap_q.pop_front();
            repeat (gap) begin
                @(negedge clock);
                inst_valid <= 1'b0;
            end
            taken = 1'b0;
            while (!taken) begin
                @(negedge clock);
                inst_valid <= 1'b1;
                inst       <= cur;
                // ready is stable until the next rising edge
                taken = inst_ready;
                if (!taken) begin
                    stall_count++;
                end
                @(posedge clock);
            end
            ref_execute(cur);
            accepted_count++;
        end
        @(negedge clock);
        inst_valid <= 1'b0;
    endtask

    ////////////////////////////////////////
    // commit checker
    ////////////////////////////////////////

    initial begin : commit_checker
        commit_t want;
        forever begin
            @(negedge clock);
            if (!reset) begin
                if (accepted_count - commit_count > ROB_DEPTH) begin
                    $display("%0d instructions in flight at %0t ns, more than the rob holds",
                             accepted_count - commit_count, $time);
                    error_count++;
                end
                if (commit_valid) begin
                    if (expected_q.size() == 0) begin
                        $display("commit at %0t ns with no instruction outstanding", $time);
                        error_count++;
                    end else begin
                        want = expected_q.pop_front();
                        check("commit rd", 32'(commit.rd), 32'(want.rd));
                        check("commit tag", 32'(commit.tag), 32'(want.tag));
                        check("commit value", commit.value, want.value);
                    end
                    commit_count++;
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, %0d of %0d instructions committed",
                 WATCHDOG_NS, commit_count, NUM_INST);
        $display("Finished with errors");
        $finish;
    end

    initial begin : main_flow
        reset          = 1'b1;
        inst_valid     = 1'b0;
        inst           = '0;
        lfsr_state     = 32'h26c757c8;
        next_tag       = '0;
        accepted_count = 0;
        commit_count   = 0;
        stall_count    = 0;
        check_count    = 0;
        error_count    = 0;
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        build_stimulus();

        repeat (5) @(posedge clock);
        @(negedge clock);
        reset <= 1'b0;

        // idle core right after reset
        repeat (4) begin
            @(negedge clock);
            check("inst_ready after reset", 32'(inst_ready), 32'd1);
            check("commit_valid after reset", 32'(commit_valid), 32'd0);
            for (int r = 0; r < NUM_REGS; r++) begin
                check($sformatf("regs[%0d] after reset", r), regs[r], 32'd0);
            end
        end

        send_all();
        wait (commit_count == NUM_INST);
        repeat (3) @(negedge clock);

        // final architectural state
        for (int r = 0; r < NUM_REGS; r++) begin
            check($sformatf("final regs[%0d]", r), regs[r], model_regs[r]);
        end
        if (expected_q.size() != 0) begin
            $display("%0d expected commits never arrived", expected_q.size());
            error_count++;
        end
        // the full rob must have pushed back at least once
        if (stall_count == 0) begin
            $display("inst_ready never dropped while instructions were offered");
            error_count++;
        end

        $display("%0d instructions, %0d stalled offers, %0d checks, %0d errors",
                 accepted_count, stall_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* ooo_core.f */
src/ooo_pkg.sv
src/dispatch_unit.sv
src/exec_lane.sv
src/cdb_arbiter.sv
src/reorder_buffer.sv
src/register_status.sv
src/ooo_core.sv
sim/ooo_core_tb.sv

/* Makefile */
BIN := obj_dir/Vooo_core_tb

.PHONY: all run clean

all: run

$(BIN): ooo_core.f $(wildcard src/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing -j 0 --top-module ooo_core_tb -f ooo_core.f

run: $(BIN)
	./$(BIN) | tee sim.log
	@if grep -q "Finished with errors" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
